// File: hw/cpu_pkg.sv
package cpu_pkg;

    // Word addressed machine, so addresses share the data width
    typedef logic [31:0] word_t;    // Data word, address or instruction
    typedef logic [3:0]  reg_idx_t;
    typedef logic [11:0] imm_t;     // Raw immediate, sign-extended in execute
    typedef logic [3:0]  op_t;
    typedef logic [1:0]  deref_t;

    // Register 15 aliases the program counter
    localparam reg_idx_t PC_INDEX = 4'd15;

    // Dereference modes
    localparam deref_t DEREF_REG     = 2'b00; // Z <- result
    localparam deref_t DEREF_LOAD    = 2'b01; // Z <- [result]
    localparam deref_t DEREF_STORE_Z = 2'b10; // [Z] <- result
    localparam deref_t DEREF_STORE_R = 2'b11; // [result] <- Z

    // Operation codes
    localparam op_t OP_OR   = 4'b0000;
    localparam op_t OP_AND  = 4'b0001;
    localparam op_t OP_ADD  = 4'b0010;
    localparam op_t OP_MUL  = 4'b0011;
    // 4'b0100 is reserved
    localparam op_t OP_SHL  = 4'b0101;
    localparam op_t OP_CLE  = 4'b0110; // Signed <=, all ones when true
    localparam op_t OP_CEQ  = 4'b0111;
    localparam op_t OP_NOR  = 4'b1000;
    localparam op_t OP_NAND = 4'b1001;
    localparam op_t OP_XOR  = 4'b1010;
    localparam op_t OP_SUB  = 4'b1011;
    localparam op_t OP_XORN = 4'b1100; // X xor ones' complement of operand
    localparam op_t OP_SHR  = 4'b1101; // Logical shift
    localparam op_t OP_CGT  = 4'b1110; // Signed >
    localparam op_t OP_CNE  = 4'b1111;

    // Control states of the core
    typedef enum logic [2:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM_ISSUE,
        ST_LOAD_WAIT,
        ST_HALT
    } ctrl_state_t;

endpackage

// File: hw/reg_file.sv
`timescale 1ns/100ps

module reg_file import cpu_pkg::*; (
    input  logic     i_clk,
    input  logic     i__reset,
    input  reg_idx_t i_rd_x,
    input  reg_idx_t i_rd_y,
    input  word_t    i_pc,
    output word_t    o_val_x,
    output word_t    o_val_y,
    output word_t    o_val_z,
    input  logic     i_wr_en,
    input  reg_idx_t i_wr_idx,
    input  word_t    i_wr_data,
    input  reg_idx_t i_rd_z
);

    // Only 1 to 14 are real storage
    word_t regs [1:14];

    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == '0)
            val = '0;
        else if (idx == PC_INDEX)
            val = i_pc + 32'd1; // Address of the next instruction
        else
            val = regs[idx];
        return val;
    endfunction

    assign o_val_x = read_port(i_rd_x);
    assign o_val_y = read_port(i_rd_y);
    assign o_val_z = read_port(i_rd_z);

    always_ff @(posedge i_clk) begin
        if (!i__reset) begin
            for (int i = 1; i <= 14; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_wr_idx != '0 && i_wr_idx != PC_INDEX) begin
            regs[i_wr_idx] <= i_wr_data; // Jumps are taken by the controller
        end
    end

endmodule

// File: hw/insn_decode.sv
`timescale 1ns/100ps

module insn_decode import cpu_pkg::*; (
    input  word_t    i_insn,
    output reg_idx_t o_z,
    output reg_idx_t o_x,
    output reg_idx_t o_y,
    output op_t      o_op,
    output imm_t     o_imm,
    output logic     o_type,
    output deref_t   o_deref,
    output logic     o_illegal
);

    // Instruction layout
    //   31     illegal marker
    //   30     type
    //   29:28  deref
    //   27:24  Z
    //   23:20  X
    //   19:16  Y
    //   15:12  op
    //   11:0   immediate

    logic   illegal_bit;
    logic   type_bit;
    deref_t deref_field;

    assign illegal_bit = i_insn[31];
    assign type_bit    = i_insn[30];
    assign deref_field = i_insn[29:28];

    // Register indices
    assign o_z = i_insn[27:24];
    assign o_x = i_insn[23:20];
    assign o_y = i_insn[19:16];

    // Operation and immediate
    assign o_op  = i_insn[15:12];
    assign o_imm = i_insn[11:0];

    assign o_type  = type_bit;
    assign o_deref = deref_field;

    // Any word with the top bit set halts the core
    assign o_illegal = illegal_bit;

endmodule

// File: hw/alu_exec.sv
`timescale 1ns/100ps

module alu_exec import cpu_pkg::*; (
    input  word_t i_x,
    input  word_t i_y,
    input  imm_t  i_imm,
    input  op_t   i_op,
    input  logic  i_type,
    output word_t o_rhs
);

    word_t      imm_ext;
    word_t      operand;  // Right side of the operation
    word_t      addend;   // Added after the operation
    word_t      result;
    logic [4:0] shamt;
    logic       lt_eq;
    logic       gt;
    logic       eq;

    assign imm_ext = {{20{i_imm[11]}}, i_imm};

    // Type 0 is X op Y + I, type 1 is X op I + Y
    assign operand = i_type ? imm_ext : i_y;
    assign addend  = i_type ? i_y : imm_ext;

    assign shamt = operand[4:0];

    // Signed compares
    assign lt_eq = $signed(i_x) <= $signed(operand);
    assign gt    = $signed(i_x) > $signed(operand);
    assign eq    = i_x == operand;

    always_comb begin
        case (i_op)
            OP_OR:   result = i_x | operand;
            OP_AND:  result = i_x & operand;
            OP_ADD:  result = i_x + operand;
            OP_MUL:  result = i_x * operand;   // Low word only
            OP_SHL:  result = i_x << shamt;
            OP_CLE:  result = {32{lt_eq}};
            OP_CEQ:  result = {32{eq}};
            OP_NOR:  result = ~(i_x | operand);
            OP_NAND: result = ~(i_x & operand);
            OP_XOR:  result = i_x ^ operand;
            OP_SUB:  result = i_x - operand;
            OP_XORN: result = i_x ^ ~operand;
            OP_SHR:  result = i_x >> shamt;
            OP_CGT:  result = {32{gt}};
            OP_CNE:  result = {32{!eq}};
            default: result = '0;              // Reserved opcode
        endcase
    end

    assign o_rhs = result + addend;

endmodule

// File: hw/credit_counter.sv
`timescale 1ns/100ps

module credit_counter #(
    parameter int unsigned CREDITS = 4
) (
    input  logic i_clk,
    input  logic i__reset,
    input  logic i_consume,
    input  logic i_return,
    output logic o_has_credit
);

    // Wide enough to hold the full credit count
    localparam int unsigned CW = $clog2(CREDITS + 1);

    logic [CW-1:0] count;

    always_ff @(posedge i_clk) begin
        if (!i__reset) begin
            count <= CW'(CREDITS);
        end else if (i_consume && !i_return) begin
            count <= count - 1'b1;
        end else if (i_return && !i_consume) begin
            count <= count + 1'b1;
        end
        // Consume and return together cancel out
    end

    assign o_has_credit = count != '0;

endmodule

// File: hw/core_ctrl.sv
`timescale 1ns/100ps

module core_ctrl import cpu_pkg::*; #(
    parameter word_t RESET_VECTOR = '0
) (
    input  logic     i_clk,
    input  logic     i__reset,
    output logic     o_halt,
    output logic     o_fetch_en,
    output word_t    o_fetch_addr,
    input  reg_idx_t i_z,
    input  deref_t   i_deref,
    input  logic     i_illegal,
    input  word_t    i_rhs,
    input  word_t    i_val_z,
    input  logic     i_mem_rsp_valid,
    input  word_t    i_mem_rsp_data,
    input  logic     i_has_credit,
    output word_t    o_pc,
    output logic     o_wr_en,
    output reg_idx_t o_wr_idx,
    output word_t    o_wr_data,
    output logic     o_consume,
    output logic     o_mem_req_valid,
    output logic     o_mem_req_write,
    output word_t    o_mem_req_addr,
    output word_t    o_mem_req_wdata
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    word_t       pc;
    logic        run_q;       // Low for the first cycle out of reset

    // Held while a request waits for a credit
    reg_idx_t load_idx_q;
    logic     req_write_q;
    word_t    req_addr_q;
    word_t    req_wdata_q;

    logic  exec_ok;           // Legal instruction in its execute cycle
    logic  exec_mem;
    logic  z_is_pc;
    word_t exec_addr;
    word_t exec_wdata;

    assign exec_ok    = (state == ST_EXEC) && !i_illegal;
    assign exec_mem   = i_deref != DEREF_REG;
    assign z_is_pc    = i_z == PC_INDEX;
    assign exec_addr  = (i_deref == DEREF_STORE_Z) ? i_val_z : i_rhs;
    assign exec_wdata = (i_deref == DEREF_STORE_R) ? i_val_z : i_rhs;

    assign o_halt       = state == ST_HALT;
    assign o_fetch_en   = (state == ST_FETCH) && run_q;
    assign o_fetch_addr = pc;
    assign o_pc         = pc;

    // Request goes out in the execute cycle when a credit is free
    assign o_mem_req_valid = ((exec_ok && exec_mem) || state == ST_MEM_ISSUE) && i_has_credit;
    assign o_mem_req_write = (state == ST_EXEC) ? i_deref[1] : req_write_q;
    assign o_mem_req_addr  = (state == ST_EXEC) ? exec_addr : req_addr_q;
    assign o_mem_req_wdata = (state == ST_EXEC) ? exec_wdata : req_wdata_q;
    assign o_consume       = o_mem_req_valid;

    // Write-back from execute or from a load response
    always_comb begin
        o_wr_en   = 1'b0;
        o_wr_idx  = i_z;
        o_wr_data = i_rhs;
        if (exec_ok && !exec_mem) begin
            o_wr_en = 1'b1;
        end else if (state == ST_LOAD_WAIT) begin
            o_wr_en   = i_mem_rsp_valid;
            o_wr_idx  = load_idx_q;
            o_wr_data = i_mem_rsp_data;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_FETCH:     state_nxt = run_q ? ST_EXEC : ST_FETCH;
            ST_EXEC: begin
                if (i_illegal)
                    state_nxt = ST_HALT;
                else if (!exec_mem)
                    state_nxt = ST_FETCH;
                else if (!i_has_credit)
                    state_nxt = ST_MEM_ISSUE;
                else
                    state_nxt = i_deref[1] ? ST_FETCH : ST_LOAD_WAIT;
            end
            ST_MEM_ISSUE: begin
                if (i_has_credit)
                    state_nxt = req_write_q ? ST_FETCH : ST_LOAD_WAIT;
            end
            ST_LOAD_WAIT: state_nxt = i_mem_rsp_valid ? ST_FETCH : ST_LOAD_WAIT;
            ST_HALT:      state_nxt = ST_HALT; // Until reset
            default:      state_nxt = ST_HALT;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i__reset) begin
            state <= ST_FETCH;
            run_q <= 1'b0;
            pc    <= RESET_VECTOR;
        end else begin
            state <= state_nxt;
            run_q <= 1'b1;
            if (exec_ok) begin
                if (z_is_pc && i_deref == DEREF_REG)
                    pc <= i_rhs;                      // Jump
                else if (!(z_is_pc && i_deref == DEREF_LOAD))
                    pc <= pc + 32'd1;
            end else if (state == ST_LOAD_WAIT && i_mem_rsp_valid && load_idx_q == PC_INDEX) begin
                pc <= i_mem_rsp_data;                 // Jump through memory
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == ST_EXEC) begin
            load_idx_q  <= i_z;
            req_write_q <= i_deref[1];
            req_addr_q  <= exec_addr;
            req_wdata_q <= exec_wdata;
        end
    end

endmodule

// File: hw/cpu_core.sv
`timescale 1ns/100ps

module cpu_core import cpu_pkg::*; #(
    parameter word_t       RESET_VECTOR = '0,
    parameter int unsigned CREDITS      = 4
) (
    input  logic  i_clk,
    input  logic  i__reset,
    output logic  o_halt,
    output logic  o_fetch_en,
    output word_t o_fetch_addr,
    input  word_t i_fetch_data,
    output logic  o_mem_req_valid,
    output logic  o_mem_req_write,
    output word_t o_mem_req_addr,
    output word_t o_mem_req_wdata,
    input  logic  i_mem_credit,
    input  logic  i_mem_rsp_valid,
    input  word_t i_mem_rsp_data
);

    reg_idx_t idx_z, idx_x, idx_y;
    op_t      op;
    imm_t     imm;
    logic     insn_type;
    deref_t   deref;
    logic     illegal;

    word_t    val_x, val_y, val_z;
    word_t    rhs;
    word_t    pc;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;
    logic     consume;
    logic     has_credit;

    // Decoded straight off the fetch port
    insn_decode u_decode (
        .i_insn(i_fetch_data), .o_z(idx_z), .o_x(idx_x), .o_y(idx_y), .o_op(op),
        .o_imm(imm), .o_type(insn_type), .o_deref(deref), .o_illegal(illegal)
    );

    reg_file u_regs (
        .i_clk(i_clk), .i__reset(i__reset), .i_rd_x(idx_x), .i_rd_y(idx_y), .i_pc(pc),
        .o_val_x(val_x), .o_val_y(val_y), .o_val_z(val_z), .i_wr_en(wr_en),
        .i_wr_idx(wr_idx), .i_wr_data(wr_data), .i_rd_z(idx_z)
    );

    alu_exec u_alu (
        .i_x(val_x), .i_y(val_y), .i_imm(imm), .i_op(op), .i_type(insn_type), .o_rhs(rhs)
    );

    credit_counter #(.CREDITS(CREDITS)) u_credits (
        .i_clk(i_clk), .i__reset(i__reset), .i_consume(consume),
        .i_return(i_mem_credit), .o_has_credit(has_credit)
    );

    core_ctrl #(.RESET_VECTOR(RESET_VECTOR)) u_ctrl (
        .i_clk(i_clk), .i__reset(i__reset), .o_halt(o_halt),
        .o_fetch_en(o_fetch_en), .o_fetch_addr(o_fetch_addr),
        .i_z(idx_z), .i_deref(deref), .i_illegal(illegal),
        .i_rhs(rhs), .i_val_z(val_z), .i_mem_rsp_valid(i_mem_rsp_valid),
        .i_mem_rsp_data(i_mem_rsp_data), .i_has_credit(has_credit),
        .o_pc(pc), .o_wr_en(wr_en), .o_wr_idx(wr_idx), .o_wr_data(wr_data),
        .o_consume(consume), .o_mem_req_valid(o_mem_req_valid),
        .o_mem_req_write(o_mem_req_write), .o_mem_req_addr(o_mem_req_addr),
        .o_mem_req_wdata(o_mem_req_wdata)
    );

endmodule

// File: dv/tb_data_mem.sv
`timescale 1ns/100ps

module tb_data_mem import cpu_pkg::*; #(
    parameter int unsigned CREDITS   = 4,
    parameter int unsigned MAX_DELAY = 6
) (
    input  logic  i_clk,
    input  logic  i__reset,
    input  logic  i_req_valid,
    input  logic  i_req_write,
    input  word_t i_req_addr,
    input  word_t i_req_wdata,
    output logic  o_credit,
    output logic  o_rsp_valid,
    output word_t o_rsp_data,
    output logic  o_overflow
);

    word_t mem [word_t];
    logic  q_write [$];
    word_t q_addr [$];
    word_t q_data [$];
    int    timer;

    // Unwritten words return a pattern of the full address
    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
    endfunction

    initial begin
        o_credit    = 1'b0;
        o_rsp_valid = 1'b0;
        o_rsp_data  = '0;
        o_overflow  = 1'b0;
    end

    always @(posedge i_clk) begin
        if (!i__reset) begin
            o_credit    <= 1'b0;
            o_rsp_valid <= 1'b0;
            o_rsp_data  <= '0;
            o_overflow  <= 1'b0;
            q_write.delete();
            q_addr.delete();
            q_data.delete();
            timer = 0;
        end else begin
            o_credit    <= 1'b0;
            o_rsp_valid <= 1'b0;
            if (q_addr.size() != 0) begin
                if (timer == 0) begin
                    if (q_write[0]) begin
                        mem[q_addr[0]] = q_data[0];
                    end else begin
                        o_rsp_valid <= 1'b1;
                        o_rsp_data  <= mem.exists(q_addr[0]) ? mem[q_addr[0]]
                                                            : fill_word(q_addr[0]);
                    end
                    o_credit <= 1'b1; // Head request retired
                    void'(q_write.pop_front());
                    void'(q_addr.pop_front());
                    void'(q_data.pop_front());
                    if (q_addr.size() != 0)
                        timer = $urandom_range(MAX_DELAY, 0);
                end else begin
                    timer--;
                end
            end
            if (i_req_valid) begin
                if (q_addr.size() == 0)
                    timer = $urandom_range(MAX_DELAY, 0);
                q_write.push_back(i_req_write);
                q_addr.push_back(i_req_addr);
                q_data.push_back(i_req_wdata);
            end
            if (q_addr.size() > CREDITS)
                o_overflow <= 1'b1;
        end
    end

endmodule

// File: dv/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb import cpu_pkg::*; ();

    localparam word_t       RESET_VECTOR = 32'd16;
    localparam int unsigned CREDITS      = 2;
    localparam int unsigned MAX_DELAY    = 6;
    localparam int          PERIOD       = 40;
    localparam int          STEP_LIMIT   = 2000;

    logic  clk;
    logic  i__reset;
    logic  halt, fetch_en, req_valid, req_write;
    word_t fetch_addr, fetch_data, req_addr, req_wdata;
    logic  mem_credit, rsp_valid, overflow;
    word_t rsp_data;

    word_t imem [0:255];
    int    prog_len;
    word_t ref_mem [word_t];
    logic  exp_write [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t exp_pc [$];
    int    ref_steps;
    logic  ref_done;
    int    checked;
    int    fetched;
    logic  halt_seen;

    cpu_core #(.RESET_VECTOR(RESET_VECTOR), .CREDITS(CREDITS)) dut0 (
        .i_clk(clk), .i__reset(i__reset), .o_halt(halt),
        .o_fetch_en(fetch_en), .o_fetch_addr(fetch_addr), .i_fetch_data(fetch_data),
        .o_mem_req_valid(req_valid), .o_mem_req_write(req_write),
        .o_mem_req_addr(req_addr), .o_mem_req_wdata(req_wdata),
        .i_mem_credit(mem_credit), .i_mem_rsp_valid(rsp_valid), .i_mem_rsp_data(rsp_data)
    );

    tb_data_mem #(.CREDITS(CREDITS), .MAX_DELAY(MAX_DELAY)) u_mem (
        .i_clk(clk), .i__reset(i__reset), .i_req_valid(req_valid),
        .i_req_write(req_write), .i_req_addr(req_addr), .i_req_wdata(req_wdata),
        .o_credit(mem_credit), .o_rsp_valid(rsp_valid), .o_rsp_data(rsp_data),
        .o_overflow(overflow)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic word_t encode(input logic ty, input deref_t dr, input reg_idx_t z,
                                     input reg_idx_t x, input reg_idx_t y, input op_t op,
                                     input imm_t imm);
        return {1'b0, ty, dr, z, x, y, op, imm};
    endfunction

    function automatic word_t fetch_word(input word_t addr);
        return (addr < 256) ? imem[addr[7:0]] : 32'h8000_0000;
    endfunction

    // Same address pattern as the memory model
    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic word_t alu_model(input op_t op, input logic ty, input word_t x,
                                        input word_t y, input imm_t imm);
        word_t ext;
        word_t b;
        word_t r;
        ext = {{20{imm[11]}}, imm};
        b   = ty ? ext : y;
        case (op)
            OP_OR:   r = x | b;
            OP_AND:  r = x & b;
            OP_ADD:  r = x + b;
            OP_MUL:  r = x * b;
            OP_SHL:  r = x << b[4:0];
            OP_CLE:  r = ($signed(x) <= $signed(b)) ? '1 : '0;
            OP_CEQ:  r = (x == b) ? '1 : '0;
            OP_NOR:  r = ~(x | b);
            OP_NAND: r = ~(x & b);
            OP_XOR:  r = x ^ b;
            OP_SUB:  r = x - b;
            OP_XORN: r = x ^ ~b;
            OP_SHR:  r = x >> b[4:0];
            OP_CGT:  r = ($signed(x) > $signed(b)) ? '1 : '0;
            OP_CNE:  r = (x != b) ? '1 : '0;
            default: r = '0;
        endcase
        return r + (ty ? y : ext);
    endfunction

    // Instruction-level model producing the expected fetch and request lists
    function automatic void run_reference();
        word_t    regs [16];
        word_t    pc;
        word_t    insn;
        word_t    rhs;
        word_t    data;
        reg_idx_t z;
        for (int i = 0; i < 16; i++) regs[i] = '0;
        pc = RESET_VECTOR;
        ref_steps = 0;
        while (ref_steps < STEP_LIMIT) begin
            insn = fetch_word(pc);
            exp_pc.push_back(pc);
            ref_steps++;
            if (insn[31])
                break;
            regs[0]  = '0;
            regs[15] = pc + 1;
            z   = insn[27:24];
            rhs = alu_model(insn[15:12], insn[30], regs[insn[23:20]], regs[insn[19:16]],
                            insn[11:0]);
            data = rhs;
            if (insn[29:28] == DEREF_LOAD) begin
                data = ref_mem.exists(rhs) ? ref_mem[rhs] : fill_word(rhs);
                exp_write.push_back(1'b0);
                exp_addr.push_back(rhs);
                exp_data.push_back('0);
            end else if (insn[29:28] == DEREF_STORE_Z) begin
                ref_mem[regs[z]] = rhs;
                exp_write.push_back(1'b1);
                exp_addr.push_back(regs[z]);
                exp_data.push_back(rhs);
            end else if (insn[29:28] == DEREF_STORE_R) begin
                ref_mem[rhs] = regs[z];
                exp_write.push_back(1'b1);
                exp_addr.push_back(rhs);
                exp_data.push_back(regs[z]);
            end
            if (!insn[29] && z == PC_INDEX)
                pc = data; // Jump
            else begin
                if (!insn[29] && z != 0)
                    regs[z] = data;
                pc = pc + 1;
            end
        end
    endfunction

    task automatic emit(input word_t w);
        imem[RESET_VECTOR + prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        int       loop_top;
        deref_t   dr;
        reg_idx_t z;
        for (int i = 0; i < 256; i++) imem[i] = 32'h8000_0000;
        prog_len = 0;
        emit(encode(0, DEREF_REG, 1, 0, 0, OP_OR, -12'sd5));
        emit(encode(0, DEREF_REG, 2, 0, 0, OP_OR, 12'd100));
        emit(encode(0, DEREF_REG, 5, 0, 0, OP_OR, 12'd200)); // Store base pointer
        for (int op = 0; op < 16; op++) begin
            for (int ty = 0; ty < 2; ty++) begin
                emit(encode(ty[0], DEREF_STORE_Z, 5, 1, 2, op[3:0],
                            12'h800 | 12'($urandom_range(2047, 0))));
                emit(encode(0, DEREF_REG, 5, 5, 0, OP_OR, 12'd1));
            end
        end
        emit(encode(0, DEREF_REG, 0, 1, 2, OP_ADD, 12'd7));        // Dropped write
        emit(encode(0, DEREF_STORE_R, 0, 5, 0, OP_OR, 12'd0));
        emit(encode(0, DEREF_REG, 5, 5, 0, OP_OR, 12'd1));
        emit(encode(0, DEREF_STORE_Z, 5, 15, 0, OP_OR, 12'd0));    // Stores pc + 1
        emit(encode(0, DEREF_REG, 5, 5, 0, OP_OR, 12'd1));
        emit(encode(0, DEREF_LOAD, 6, 5, 0, OP_OR, -12'sd3));
        emit(encode(0, DEREF_STORE_Z, 5, 6, 1, OP_XOR, 12'd3));
        emit(encode(0, DEREF_REG, 5, 5, 0, OP_OR, 12'd1));
        // Counted loop that jumps back 6 words to loop_top
        emit(encode(0, DEREF_REG, 7, 0, 0, OP_OR, 12'd5));
        loop_top = prog_len;
        emit(encode(0, DEREF_STORE_Z, 5, 7, 0, OP_OR, 12'd0));
        emit(encode(0, DEREF_REG, 5, 5, 0, OP_OR, 12'd1));
        emit(encode(1, DEREF_REG, 7, 7, 0, OP_SUB, 12'd1));
        emit(encode(0, DEREF_REG, 8, 7, 0, OP_CNE, 12'd0));
        emit(encode(1, DEREF_REG, 9, 8, 0, OP_AND, 12'(loop_top - prog_len - 2)));
        emit(encode(0, DEREF_REG, 15, 15, 9, OP_ADD, 12'd0));
        for (int i = 0; i < 6; i++) begin
            emit(encode(0, DEREF_STORE_R, 7, 5, 0, OP_OR, 12'(i))); // Burst against credits
        end
        for (int i = 0; i < 40; i++) begin
            dr = 2'($urandom_range(3, 0));
            z  = dr[1] ? 4'($urandom_range(15, 0)) : 4'($urandom_range(14, 1));
            emit(encode(1'($urandom_range(1, 0)), dr, z, 4'($urandom_range(15, 0)),
                        4'($urandom_range(15, 0)), 4'($urandom_range(15, 0)),
                        12'($urandom)));
        end
        emit(32'h8000_0000);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string field, input word_t got, input word_t exp);
        report_failure($sformatf("error %0t: %s got %h expected %h", $time, field, got, exp));
    endtask

    // Fetch port with one cycle of latency
    always @(posedge clk) begin
        if (fetch_en)
            fetch_data <= fetch_word(fetch_addr);
    end

    // Compare every fetch and request against the model
    always @(posedge clk) begin
        if (i__reset) begin
            assert (!overflow) else report_failure("More requests outstanding than credits");
            assert (!(halt_seen && (fetch_en || req_valid)))
                else report_failure("Core fetched or requested after halting");
            if (halt)
                halt_seen <= 1'b1;
            if (fetch_en) begin
                assert (fetched < exp_pc.size())
                    else report_failure("Core fetched more instructions than expected");
                assert (fetch_addr == exp_pc[fetched])
                    else report_mismatch("fetch address", fetch_addr, exp_pc[fetched]);
                fetched++;
            end
            if (req_valid) begin
                assert (checked < exp_write.size())
                    else report_failure("Core sent more requests than expected");
                assert (req_write == exp_write[checked])
                    else report_mismatch("write flag", 32'(req_write), 32'(exp_write[checked]));
                assert (req_addr == exp_addr[checked])
                    else report_mismatch("address", req_addr, exp_addr[checked]);
                assert (!req_write || req_wdata == exp_data[checked])
                    else report_mismatch("write data", req_wdata, exp_data[checked]);
                checked++;
            end
        end
    end

    initial begin
        i__reset   = 1'b0;
        fetch_data = '0;
        checked    = 0;
        fetched    = 0;
        halt_seen  = 1'b0;
        ref_done   = 1'b0;
        void'($urandom(32'h632a_c60e));
        build_program();
        run_reference();
        ref_done = 1'b1;
        repeat (2) @(posedge clk);
        i__reset <= 1'b1;
        do @(posedge clk); while (!halt);
        repeat (10) @(posedge clk);
        if (checked == exp_write.size() && fetched == exp_pc.size()) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            report_failure($sformatf("Saw %0d of %0d requests and %0d of %0d fetches",
                                     checked, exp_write.size(), fetched, exp_pc.size()));
        end
    end

    initial begin
        wait (ref_done);
        repeat (ref_steps * (8 + MAX_DELAY) + 20) @(posedge clk);
        report_failure("Watchdog expired before the core halted");
    end

endmodule

// File: tb.f
hw/cpu_pkg.sv
hw/reg_file.sv
hw/insn_decode.sv
hw/alu_exec.sv
hw/credit_counter.sv
hw/core_ctrl.sv
hw/cpu_core.sv
dv/tb_data_mem.sv
dv/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR) -f tb.f
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
